// ==== logic/matrix_defines.svh ====
`ifndef MATRIX_DEFINES_SVH
`define MATRIX_DEFINES_SVH

// Panel geometry
`define MATRIX_COLS           64
`define MATRIX_ROW_BITS       5
`define MATRIX_ADDR_BITS      6
`define MATRIX_PIXEL_BITS     8
`define MATRIX_ROW_BITS_TOTAL 512

// Pixel layout is RRRGGGBB
`define MATRIX_R_LSB   5
`define MATRIX_G_LSB   2
`define MATRIX_B_LSB   0
`define MATRIX_B_WIDTH 2

`endif

// ==== logic/matrix_pkg.sv ====
`include "matrix_defines.svh"

package matrix_pkg;

  typedef enum logic [3:0] {
    IDLE,
    FETCH_UPPER,
    RELEASE_UPPER,
    FETCH_LOWER,
    RELEASE_LOWER,
    LOAD_UPPER,
    LOAD_LOWER,
    ACK,
    SHIFT
  } rmm_state_e;

  // One column of the panel with its top and bottom halves
  typedef struct packed {
    logic [2:0] rgb_upper;
    logic [2:0] rgb_lower;
  } pixel_pair_t;

  typedef struct packed {
    logic                         req;
    logic [`MATRIX_ADDR_BITS-1:0] addr;  // Side bit above the scan row
  } vram_rd_req_t;

  typedef struct packed {
    logic                              en;
    logic [`MATRIX_ADDR_BITS-1:0]      addr;
    logic [`MATRIX_ROW_BITS_TOTAL-1:0] data;
  } vram_wr_t;

endpackage

// ==== logic/matrix_top.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module matrix_top
  import matrix_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_req,
  input  logic [`MATRIX_ROW_BITS-1:0] load_row,
  input  logic [1:0]                  plane_sel,
  output logic                        load_ack,
  input  logic                        shift,
  output pixel_pair_t                 pixels,
  input  vram_wr_t                    wr
);

  vram_rd_req_t                      vram_rd;
  logic                              rd_ack;
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] rd_data;
  logic                              row_load_upper;
  logic                              row_load_lower;
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_upper;
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_lower;
  logic                              side;
  logic                              plane_load_upper;
  logic                              plane_load_lower;
  logic [`MATRIX_COLS-1:0]           red;
  logic [`MATRIX_COLS-1:0]           green;
  logic [`MATRIX_COLS-1:0]           blue;
  logic                              shift_en;

  // Shifting waits until the load handshake has fully closed
  assign shift_en = shift && !load_req && !load_ack;

  read_memory_management u_rmm (
    .clk             (clk),
    .rst             (rst),
    .load_req        (load_req),
    .load_row        (load_row),
    .load_ack        (load_ack),
    .vram_rd         (vram_rd),
    .rd_ack          (rd_ack),
    .row_load_upper  (row_load_upper),
    .row_load_lower  (row_load_lower),
    .side            (side),
    .plane_load_upper(plane_load_upper),
    .plane_load_lower(plane_load_lower)
  );

  row_cache u_row_cache (
    .clk           (clk),
    .rst           (rst),
    .rd_data       (rd_data),
    .row_load_upper(row_load_upper),
    .row_load_lower(row_load_lower),
    .row_upper     (row_upper),
    .row_lower     (row_lower)
  );

  plane_selection u_plane_selection (
    .row_upper(row_upper),
    .row_lower(row_lower),
    .side     (side),
    .plane_sel(plane_sel),
    .red      (red),
    .green    (green),
    .blue     (blue)
  );

  plane_shifter u_plane_shifter (
    .clk             (clk),
    .rst             (rst),
    .red             (red),
    .green           (green),
    .blue            (blue),
    .plane_load_upper(plane_load_upper),
    .plane_load_lower(plane_load_lower),
    .shift           (shift_en),
    .pixels          (pixels)
  );

  vram u_vram (
    .clk    (clk),
    .rst    (rst),
    .wr     (wr),
    .rd     (vram_rd),
    .rd_ack (rd_ack),
    .rd_data(rd_data)
  );

endmodule

// ==== logic/plane_selection.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module plane_selection (
  input  logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_upper,
  input  logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_lower,
  input  logic                              side,
  input  logic [1:0]                        plane_sel,
  output logic [`MATRIX_COLS-1:0]           red,
  output logic [`MATRIX_COLS-1:0]           green,
  output logic [`MATRIX_COLS-1:0]           blue
);

  localparam int R_WIDTH = `MATRIX_PIXEL_BITS - `MATRIX_R_LSB;
  localparam int G_WIDTH = `MATRIX_R_LSB - `MATRIX_G_LSB;

  always_comb begin
    logic [`MATRIX_ROW_BITS_TOTAL-1:0] row;
    logic [`MATRIX_PIXEL_BITS-1:0]     pix;
    logic [`MATRIX_PIXEL_BITS-1:0]     pix_r;
    logic [`MATRIX_PIXEL_BITS-1:0]     pix_g;
    logic [`MATRIX_PIXEL_BITS-1:0]     pix_b;

    row = side ? row_lower : row_upper;
    for (int i = 0; i < `MATRIX_COLS; i++) begin
      pix   = row[i*`MATRIX_PIXEL_BITS +: `MATRIX_PIXEL_BITS];
      pix_r = pix >> `MATRIX_R_LSB;
      pix_g = pix >> `MATRIX_G_LSB;
      pix_b = pix >> `MATRIX_B_LSB;
      // Planes past a field's width read as dark
      red[i]   = (plane_sel < R_WIDTH) && pix_r[plane_sel];
      green[i] = (plane_sel < G_WIDTH) && pix_g[plane_sel];
      blue[i]  = (plane_sel < `MATRIX_B_WIDTH) && pix_b[plane_sel];
    end
  end

endmodule

// ==== logic/plane_shifter.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module plane_shifter
  import matrix_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`MATRIX_COLS-1:0] red,
  input  logic [`MATRIX_COLS-1:0] green,
  input  logic [`MATRIX_COLS-1:0] blue,
  input  logic                    plane_load_upper,
  input  logic                    plane_load_lower,
  input  logic                    shift,
  output pixel_pair_t             pixels
);

  // Index 2 is red, 1 green, 0 blue
  logic [2:0][`MATRIX_COLS-1:0] upper_q;
  logic [2:0][`MATRIX_COLS-1:0] lower_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      upper_q <= '0;
      lower_q <= '0;
    end else begin
      if (shift) begin
        for (int c = 0; c < 3; c++) begin
          upper_q[c] <= {1'b0, upper_q[c][`MATRIX_COLS-1:1]};
          lower_q[c] <= {1'b0, lower_q[c][`MATRIX_COLS-1:1]};
        end
      end
      // A parallel load wins over a shift
      if (plane_load_upper) upper_q <= {red, green, blue};
      if (plane_load_lower) lower_q <= {red, green, blue};
    end
  end

  // Column 0 leaves first
  assign pixels.rgb_upper = {upper_q[2][0], upper_q[1][0], upper_q[0][0]};
  assign pixels.rgb_lower = {lower_q[2][0], lower_q[1][0], lower_q[0][0]};

endmodule

// ==== logic/read_memory_management.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module read_memory_management
  import matrix_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        load_req,
  input  logic [`MATRIX_ROW_BITS-1:0] load_row,
  output logic                        load_ack,
  output vram_rd_req_t                vram_rd,
  input  logic                        rd_ack,
  output logic                        row_load_upper,
  output logic                        row_load_lower,
  output logic                        side,
  output logic                        plane_load_upper,
  output logic                        plane_load_lower
);

  rmm_state_e state;
  rmm_state_e state_next;

  logic [`MATRIX_ROW_BITS-1:0] tag;
  logic                        tag_valid;
  logic                        hit;

  assign hit = tag_valid && (tag == load_row);

  // ------------------------------
  // State and cache tag
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      tag       <= '0;
      tag_valid <= 1'b0;
    end else begin
      state <= state_next;
      // The cache gets overwritten half by half on a miss
      if ((state == IDLE || state == SHIFT) && load_req && !hit) begin
        tag_valid <= 1'b0;
      end
      if (state == RELEASE_LOWER && !rd_ack) begin
        tag       <= load_row;
        tag_valid <= 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE, SHIFT: begin
        if (load_req) begin
          state_next = hit ? LOAD_UPPER : FETCH_UPPER;
        end
      end
      FETCH_UPPER: begin
        if (rd_ack) state_next = RELEASE_UPPER;
      end
      RELEASE_UPPER: begin
        if (!rd_ack) state_next = FETCH_LOWER;  // Wait out the fourth phase
      end
      FETCH_LOWER: begin
        if (rd_ack) state_next = RELEASE_LOWER;
      end
      RELEASE_LOWER: begin
        if (!rd_ack) state_next = LOAD_UPPER;
      end
      LOAD_UPPER: state_next = LOAD_LOWER;
      LOAD_LOWER: state_next = ACK;
      ACK: begin
        if (!load_req) state_next = SHIFT;  // Planes stay loaded for streaming
      end
      default: state_next = IDLE;
    endcase
  end

  // ------------------------------
  // Outputs
  // ------------------------------
  always_comb begin
    side = (state == FETCH_LOWER) || (state == RELEASE_LOWER) || (state == LOAD_LOWER);

    vram_rd.req  = (state == FETCH_UPPER) || (state == FETCH_LOWER);
    vram_rd.addr = {side, load_row};

    // Strobes line up with the cycle where read data is valid
    row_load_upper = (state == FETCH_UPPER) && rd_ack;
    row_load_lower = (state == FETCH_LOWER) && rd_ack;

    plane_load_upper = (state == LOAD_UPPER);
    plane_load_lower = (state == LOAD_LOWER);
    load_ack         = (state == ACK);
  end

endmodule

// ==== logic/row_cache.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module row_cache (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [`MATRIX_ROW_BITS_TOTAL-1:0] rd_data,
  input  logic                              row_load_upper,
  input  logic                              row_load_lower,
  output logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_upper,
  output logic [`MATRIX_ROW_BITS_TOTAL-1:0] row_lower
);

  // Upper half of the panel
  always_ff @(posedge clk) begin
    if (rst) begin
      row_upper <= '0;
    end else if (row_load_upper) begin
      row_upper <= rd_data;
    end
  end

  // Lower half holds the same scan row with the side bit set
  always_ff @(posedge clk) begin
    if (rst) begin
      row_lower <= '0;
    end else if (row_load_lower) begin
      row_lower <= rd_data;
    end
  end

endmodule

// ==== logic/vram.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module vram
  import matrix_pkg::*;
(
  input  logic                              clk,
  input  logic                              rst,
  input  vram_wr_t                          wr,
  input  vram_rd_req_t                      rd,
  output logic                              rd_ack,
  output logic [`MATRIX_ROW_BITS_TOTAL-1:0] rd_data
);

  localparam int DEPTH = 1 << `MATRIX_ADDR_BITS;

  logic [`MATRIX_ROW_BITS_TOTAL-1:0] mem [DEPTH];
  logic                              lat_cnt;

  always_ff @(posedge clk) begin
    if (wr.en) mem[wr.addr] <= wr.data;  // Host port writes one row word per cycle
  end

  // ------------------------------
  // Read handshake
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ack  <= 1'b0;
      lat_cnt <= 1'b0;
    end else if (!rd.req) begin
      rd_ack  <= 1'b0;
      lat_cnt <= 1'b0;
    end else if (!rd_ack) begin
      // Acknowledge on the second cycle of a held request
      if (lat_cnt) rd_ack <= 1'b1;
      lat_cnt <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rd.req && !rd_ack && lat_cnt) rd_data <= mem[rd.addr];
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the matrix testbench with Verilator.
set -u

cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module matrix_tb -Mdir obj_dir -o matrix_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/matrix_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^test passed$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== verif/matrix_tb.sv ====
`timescale 1ns/1ps
`include "matrix_defines.svh"

module matrix_tb
  import matrix_pkg::*;
();

  localparam int CLK_PERIOD      = 100;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 500;
  localparam int LOAD_TIMEOUT    = 40;
  localparam logic [`MATRIX_ROW_BITS-1:0] ROW_A = 5'd5;
  localparam logic [`MATRIX_ROW_BITS-1:0] ROW_B = 5'd17;

  logic                        clk;
  logic                        rst;
  logic                        load_req;
  logic [`MATRIX_ROW_BITS-1:0] load_row;
  logic [1:0]                  plane_sel;
  logic                        load_ack;
  logic                        shift;
  pixel_pair_t                 pixels;
  vram_wr_t                    wr;

  // Mirror of the VRAM and of the two rows the DUT should hold in its cache
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] model [1 << `MATRIX_ADDR_BITS];
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] cache_upper;
  logic [`MATRIX_ROW_BITS_TOTAL-1:0] cache_lower;
  logic [`MATRIX_ROW_BITS-1:0]       cached_row;
  logic                              cached_valid;
  int                                errors;
  int                                checks;
  int                                latency;

  matrix_top u_dut (.*);

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("test failed");
    $finish;
  end

  // ------------------------------
  // Reference model and checks
  // ------------------------------
  function automatic logic [2:0] expected_rgb(input logic [`MATRIX_ROW_BITS_TOTAL-1:0] word,
                                              input int col, input logic [1:0] plane);
    logic [`MATRIX_PIXEL_BITS-1:0] pix;
    pix = word[col*`MATRIX_PIXEL_BITS +: `MATRIX_PIXEL_BITS];
    case (plane)
      2'd0:    return {pix[`MATRIX_R_LSB], pix[`MATRIX_G_LSB], pix[`MATRIX_B_LSB]};
      2'd1:    return {pix[`MATRIX_R_LSB+1], pix[`MATRIX_G_LSB+1], pix[`MATRIX_B_LSB+1]};
      2'd2:    return {pix[`MATRIX_R_LSB+2], pix[`MATRIX_G_LSB+2], 1'b0};  // Blue has two bits
      default: return 3'b000;
    endcase
  endfunction

  function automatic logic [`MATRIX_ROW_BITS_TOTAL-1:0] random_row();
    logic [`MATRIX_ROW_BITS_TOTAL-1:0] w;
    for (int i = 0; i < `MATRIX_ROW_BITS_TOTAL / 32; i++) w[i*32 +: 32] = $urandom();
    return w;
  endfunction

  task automatic check_pixels(input pixel_pair_t got, input pixel_pair_t exp, input int col);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] pixels col %0d: got 0x%h, expected 0x%h", col, got, exp);
    end
  endtask

  task automatic check_ack(input logic got, input logic exp, input string phase);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] load_ack %s: got 0x%h, expected 0x%h", phase, got, exp);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] load_ack latency: got 0x%h, expected 0x%h", got, exp);
    end
  endtask

  // ------------------------------
  // Bus drivers
  // ------------------------------
  task automatic write_row(input logic [`MATRIX_ADDR_BITS-1:0] addr,
                           input logic [`MATRIX_ROW_BITS_TOTAL-1:0] data);
    @(posedge clk);
    wr <= '{en: 1'b1, addr: addr, data: data};
    model[addr] = data;
    @(posedge clk);
    wr.en <= 1'b0;
  endtask

  task automatic load_plane(input logic [`MATRIX_ROW_BITS-1:0] row, input logic [1:0] plane,
                            input int hold, output int cycles);
    @(posedge clk);
    load_row  <= row;
    plane_sel <= plane;
    load_req  <= 1'b1;
    if (!cached_valid || cached_row != row) begin  // A miss refills both halves
      cache_upper  = model[{1'b0, row}];
      cache_lower  = model[{1'b1, row}];
      cached_row   = row;
      cached_valid = 1'b1;
    end
    cycles = 0;
    @(negedge clk);
    while (!load_ack && cycles < LOAD_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!load_ack) begin
      errors++;
      $display("Load of row %0d timed out waiting for load_ack", row);
    end
    repeat (hold) begin
      @(negedge clk);
      check_ack(load_ack, 1'b1, "while held");
    end
    @(posedge clk);
    load_req <= 1'b0;
    @(negedge clk);
    check_ack(load_ack, 1'b1, "in release cycle");
    @(negedge clk);
    check_ack(load_ack, 1'b0, "after release");
  endtask

  task automatic shift_row(input logic [1:0] plane);
    pixel_pair_t exp;
    @(posedge clk);
    shift <= 1'b1;
    for (int c = 0; c < `MATRIX_COLS; c++) begin
      @(negedge clk);
      exp.rgb_upper = expected_rgb(cache_upper, c, plane);
      exp.rgb_lower = expected_rgb(cache_lower, c, plane);
      check_pixels(pixels, exp, c);
    end
    @(posedge clk);
    shift <= 1'b0;
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_values();
    @(negedge clk);
    check_ack(load_ack, 1'b0, "after reset");
    check_pixels(pixels, '0, 0);
  endtask

  task automatic miss_load();
    write_row({1'b0, ROW_A}, random_row());
    write_row({1'b1, ROW_A}, random_row());
    load_plane(ROW_A, 2'd0, 0, latency);
    shift_row(2'd0);
  endtask

  task automatic higher_planes();
    load_plane(ROW_A, 2'd1, 0, latency);
    shift_row(2'd1);
    load_plane(ROW_A, 2'd2, 0, latency);
    shift_row(2'd2);
    load_plane(ROW_A, 2'd3, 0, latency);
    shift_row(2'd3);
  endtask

  task automatic hit_keeps_old_data();
    write_row({1'b0, ROW_A}, random_row());  // Cache is not invalidated by writes
    write_row({1'b1, ROW_A}, random_row());
    load_plane(ROW_A, 2'd0, 0, latency);
    check_latency(latency, 3);
    shift_row(2'd0);
  endtask

  task automatic refetch_other_row();
    write_row({1'b0, ROW_B}, random_row());
    write_row({1'b1, ROW_B}, random_row());
    load_plane(ROW_B, 2'd0, 0, latency);
    shift_row(2'd0);
    load_plane(ROW_A, 2'd0, 0, latency);
    shift_row(2'd0);
  endtask

  task automatic held_handshake();
    load_plane(ROW_A, 2'd1, 6, latency);
    shift_row(2'd1);
  endtask

  initial begin
    void'($urandom(32'h9ddd_7ed6));
    rst       <= 1'b1;
    load_req  <= 1'b0;
    load_row  <= '0;
    plane_sel <= '0;
    shift     <= 1'b0;
    wr        <= '0;
    errors       = 0;
    checks       = 0;
    cached_valid = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    reset_values();
    miss_load();
    higher_planes();
    hit_keeps_old_data();
    refetch_other_row();
    held_handshake();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/matrix_pkg.sv
logic/read_memory_management.sv
logic/plane_selection.sv
logic/row_cache.sv
logic/plane_shifter.sv
logic/vram.sv
logic/matrix_top.sv
verif/matrix_tb.sv
